// ==== hdl/credit_link_params.svh ====
// Credit link configuration
// Buffer depth, flit width, link delay and credit return batch size
// shared by every block of the link

`ifndef CREDIT_LINK_PARAMS_SVH
`define CREDIT_LINK_PARAMS_SVH

// Receiver FIFO slots, also the largest credit count
`define CL_FIFO_DEPTH 8

// Payload bits per flit
`define CL_DATA_W 16

// Register stages in each direction of the link
`define CL_LINK_LAT 2

// Most credits returned in one cycle, no more than CL_FIFO_DEPTH
`define CL_MAX_RET 2

`endif

// ==== hdl/credit_link_pkg.sv ====
// Credit link types
// Flit layout and the counts used for credits and credit returns

`include "credit_link_params.svh"

package credit_link_pkg;

  // Count widths
  localparam int CREDIT_W = $clog2(`CL_FIFO_DEPTH + 1);
  localparam int RET_W    = $clog2(`CL_MAX_RET + 1);

  // 0 .. CL_FIFO_DEPTH
  typedef logic [CREDIT_W-1:0] credit_t;

  // 0 .. CL_MAX_RET
  typedef logic [RET_W-1:0] ret_t;

  // One flit on the link
  typedef struct packed {
    logic [`CL_DATA_W-1:0] data;
    logic                  last;
  } flit_t;

endpackage

// ==== hdl/credit_link_if.sv ====
// Credit link channel
// Flits travel forward from sender to receiver, credit returns travel
// backward. Both directions are single-cycle strobes with no stall

`timescale 1ns/1ps

`include "credit_link_params.svh"

interface credit_link_if (
  input logic clk
);
  import credit_link_pkg::*;

  // Forward path, one flit per pulse
  logic  flit_valid;
  flit_t flit;

  // Backward path, crd_count credits per pulse
  logic  crd_valid;
  ret_t  crd_count;

  // Sender end
  modport tx (
    input  clk,
    output flit_valid,
    output flit,
    input  crd_valid,
    input  crd_count
  );

  // Receiver end
  modport rx (
    input  clk,
    input  flit_valid,
    input  flit,
    output crd_valid,
    output crd_count
  );

endinterface

// ==== hdl/credit_counter.sv ====
// Credit counter
// Holds a pool of credits with independent increment and decrement in
// the same cycle. The decrement is refused when it would take more than
// is available, so the pool cannot underflow. Credits can be withheld
// at run time, and the reset value comes in on a port

`timescale 1ns/1ps

`include "credit_link_params.svh"

module credit_counter (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     incr_valid,
  input  credit_link_pkg::ret_t    incr,
  input  logic                     decr_valid,
  input  credit_link_pkg::ret_t    decr,
  input  credit_link_pkg::credit_t initial_value,
  input  credit_link_pkg::credit_t withhold,
  output logic                     decr_ready,
  output credit_link_pkg::credit_t value,
  output credit_link_pkg::credit_t available
);
  import credit_link_pkg::*;

  // One spare bit so sums and differences cannot wrap
  localparam int CALC_W = CREDIT_W + 1;
  localparam logic [CALC_W-1:0] MAX_VAL = CALC_W'(`CL_FIFO_DEPTH);

  // ----------------------------
  // Arithmetic
  // ----------------------------

  logic [CALC_W-1:0] incr_ext;
  logic [CALC_W-1:0] decr_ext;
  logic [CALC_W-1:0] hold_ext;
  logic [CALC_W-1:0] sum_ext;
  logic [CALC_W-1:0] avail_ext;
  logic [CALC_W-1:0] diff_ext;
  logic [CALC_W-1:0] next_ext;

  // Increment only counts when it is valid
  assign incr_ext = incr_valid ? CALC_W'(incr) : '0;

  // Decrement only counts when valid and accepted
  assign decr_ext = (decr_valid && decr_ready) ? CALC_W'(decr) : '0;

  assign hold_ext = CALC_W'(withhold);

  // Pool plus this cycle's returns
  assign sum_ext = CALC_W'(value) + incr_ext;

  // Available includes the increment but not the decrement,
  // which keeps decr_ready free of a loop through decr_valid
  assign avail_ext = (sum_ext > hold_ext) ? sum_ext - hold_ext : '0;

  // Clamp to the pool size
  assign available = (avail_ext > MAX_VAL) ? CREDIT_W'(MAX_VAL) : CREDIT_W'(avail_ext);

  // Ready looks at the amount only, never at decr_valid
  assign decr_ready = CALC_W'(decr) <= CALC_W'(available);

  // Accepted decrements never exceed the sum, floor kept for safety
  assign diff_ext = (sum_ext >= decr_ext) ? sum_ext - decr_ext : '0;

  // Saturate at the pool size
  assign next_ext = (diff_ext > MAX_VAL) ? MAX_VAL : diff_ext;

  // ----------------------------
  // Pool register
  // ----------------------------

  // Loads the initial value for as long as reset is held
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      value <= initial_value;
    end else begin
      value <= CREDIT_W'(next_ext);
    end
  end

endmodule

// ==== hdl/credit_sender.sv ====
// Credit link sender
// Accepts flits from the source while credits remain, then delays
// them through the link stages. Returned credits come back through
// the same number of stages before they refill the pool

`timescale 1ns/1ps

`include "credit_link_params.svh"

module credit_sender (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     src_valid,
  input  credit_link_pkg::flit_t   src_flit,
  input  credit_link_pkg::credit_t init_credit,
  input  credit_link_pkg::credit_t withhold,
  output logic                     src_ready,
  output credit_link_pkg::credit_t credits,
  credit_link_if.tx                link
);
  import credit_link_pkg::*;

  localparam int LAT = `CL_LINK_LAT;

  logic           xfer;

  // Forward stages
  logic [LAT-1:0] flit_vld_q;
  flit_t          flit_q [LAT];

  // Backward stages
  logic [LAT-1:0] crd_vld_q;
  ret_t           crd_cnt_q [LAT];

  // ----------------------------
  // Free receiver slots
  // ----------------------------

  // Each accepted flit spends one credit
  credit_counter u_credits (
    .clk           (clk),
    .arst_n        (arst_n),
    .incr_valid    (crd_vld_q[LAT-1]),
    .incr          (crd_cnt_q[LAT-1]),
    .decr_valid    (src_valid),
    .decr          (ret_t'(1)),
    .initial_value (init_credit),
    .withhold      (withhold),
    .decr_ready    (src_ready),
    .value         (credits),
    .available     ()
  );

  assign xfer = src_valid && src_ready;

  // ----------------------------
  // Link delay stages
  // ----------------------------

  // Strobes, cleared by reset
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      flit_vld_q <= '0;
      crd_vld_q  <= '0;
    end else begin
      flit_vld_q[0] <= xfer;
      crd_vld_q[0]  <= link.crd_valid;
      for (int i = 1; i < LAT; i++) begin
        flit_vld_q[i] <= flit_vld_q[i-1];
        crd_vld_q[i]  <= crd_vld_q[i-1];
      end
    end
  end

  // Payloads just follow their strobes
  always_ff @(posedge clk) begin
    flit_q[0]    <= src_flit;
    crd_cnt_q[0] <= link.crd_count;
    for (int i = 1; i < LAT; i++) begin
      flit_q[i]    <= flit_q[i-1];
      crd_cnt_q[i] <= crd_cnt_q[i-1];
    end
  end

  // Last stage drives the link
  assign link.flit_valid = flit_vld_q[LAT-1];
  assign link.flit       = flit_q[LAT-1];

endmodule

// ==== hdl/credit_fifo.sv ====
// Receiver flit buffer
// Circular buffer with an occupancy count. A write into a full buffer
// is dropped and sets a sticky overflow flag

`timescale 1ns/1ps

`include "credit_link_params.svh"

module credit_fifo (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   wr_en,
  input  credit_link_pkg::flit_t wr_flit,
  input  logic                   rd_en,
  output credit_link_pkg::flit_t rd_flit,
  output logic                   empty,
  output logic                   full
);
  import credit_link_pkg::*;

  localparam int DEPTH = `CL_FIFO_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);

  flit_t            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  credit_t          count;
  logic             overflow;
  logic             do_wr;
  logic             do_rd;

  assign empty = (count == '0);
  assign full  = (count == CREDIT_W'(DEPTH));

  assign do_rd = rd_en && !empty;
  assign do_wr = wr_en && !full;

  // Head of the buffer, shown without a read latency
  assign rd_flit = mem[rd_ptr];

  // Storage
  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_flit;
    end
  end

  // Pointers wrap at DEPTH, which need not be a power of two
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      end
      // Occupancy moves only when exactly one side is active
      if (do_wr && !do_rd) begin
        count <= count + 1'b1;
      end else if (do_rd && !do_wr) begin
        count <= count - 1'b1;
      end
      // Sticky once a write is lost
      overflow <= overflow || (wr_en && full);
    end
  end

endmodule

// ==== hdl/credit_receiver.sv ====
// Credit link receiver
// Buffers arriving flits and presents the buffer head to the sink.
// Every pop owes the sender one credit. Owed credits go back in
// batches of up to CL_MAX_RET per cycle

`timescale 1ns/1ps

`include "credit_link_params.svh"

module credit_receiver (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   snk_ready,
  output logic                   snk_valid,
  output credit_link_pkg::flit_t snk_flit,
  credit_link_if.rx              link
);
  import credit_link_pkg::*;

  localparam credit_t MAX_RET = CREDIT_W'(`CL_MAX_RET);

  logic    fifo_empty;
  logic    pop;
  credit_t owed_avail;
  ret_t    ret_amt;

  // ----------------------------
  // Flit buffer
  // ----------------------------

  // Every arriving flit has a credit behind it, so the buffer
  // has room for it
  credit_fifo u_fifo (
    .clk     (clk),
    .arst_n  (arst_n),
    .wr_en   (link.flit_valid),
    .wr_flit (link.flit),
    .rd_en   (pop),
    .rd_flit (snk_flit),
    .empty   (fifo_empty),
    .full    ()
  );

  // Sink sees the head as soon as the write has landed
  assign snk_valid = !fifo_empty;
  assign pop       = snk_valid && snk_ready;

  // ----------------------------
  // Owed credits
  // ----------------------------

  // Starts empty with nothing withheld
  credit_counter u_owed (
    .clk           (clk),
    .arst_n        (arst_n),
    .incr_valid    (pop),
    .incr          (ret_t'(1)),
    .decr_valid    (link.crd_valid),
    .decr          (ret_amt),
    .initial_value ('0),
    .withhold      ('0),
    .decr_ready    (),
    .value         (),
    .available     (owed_avail)
  );

  // Batch is the lesser of what is owed and the per-cycle cap.
  // Owed includes the pop of this cycle
  assign ret_amt = (owed_avail > MAX_RET) ? RET_W'(MAX_RET) : RET_W'(owed_avail);

  // A nonzero batch always fits in what is owed
  assign link.crd_valid = (ret_amt != '0);
  assign link.crd_count = ret_amt;

endmodule

// ==== hdl/credit_link_top.sv ====
// Credit link top level
// Joins the sender and the receiver over the link channel. Source and
// sink handshakes and the credit controls are plain ports

`timescale 1ns/1ps

`include "credit_link_params.svh"

module credit_link_top (
  input  logic                     clk,
  input  logic                     arst_n,
  // Source side
  input  logic                     src_valid,
  input  credit_link_pkg::flit_t   src_flit,
  output logic                     src_ready,
  // Sink side
  output logic                     snk_valid,
  output credit_link_pkg::flit_t   snk_flit,
  input  logic                     snk_ready,
  // Credit control and status
  input  credit_link_pkg::credit_t init_credit,
  input  credit_link_pkg::credit_t withhold,
  output credit_link_pkg::credit_t credits
);

  // ----------------------------
  // Link channel
  // ----------------------------

  credit_link_if u_link (
    .clk (clk)
  );

  // ----------------------------
  // Ends of the link
  // ----------------------------

  credit_sender u_sender (
    .clk         (clk),
    .arst_n      (arst_n),
    .src_valid   (src_valid),
    .src_flit    (src_flit),
    .init_credit (init_credit),
    .withhold    (withhold),
    .src_ready   (src_ready),
    .credits     (credits),
    .link        (u_link.tx)
  );

  // Receiver buffer depth matches the sender's full credit pool
  credit_receiver u_receiver (
    .clk       (clk),
    .arst_n    (arst_n),
    .snk_ready (snk_ready),
    .snk_valid (snk_valid),
    .snk_flit  (snk_flit),
    .link      (u_link.rx)
  );

endmodule

// ==== sim/credit_link_chk.sv ====
// Credit link checker
// Concurrent assertions on the link top level, for buffer safety,
// credit bounds and the state just after reset

`timescale 1ns/1ps

`include "credit_link_params.svh"

module credit_link_chk (
  input logic                     clk,
  input logic                     arst_n,
  input logic                     src_valid,
  input logic                     src_ready,
  input logic                     snk_valid,
  input credit_link_pkg::credit_t credits,
  input credit_link_pkg::credit_t withhold,
  input credit_link_pkg::credit_t init_credit,
  input logic                     ret_valid,
  input credit_link_pkg::ret_t    ret_count,
  input logic                     crd_valid,
  input credit_link_pkg::ret_t    crd_count,
  input logic                     overflow
);
  import credit_link_pkg::*;

  int fail_count = 0;
  int in_flight;
  int free_now;

  // Flits sent whose credit has not come back yet
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      in_flight <= 0;
    end else begin
      in_flight <= in_flight + int'(src_valid && src_ready)
                   - (ret_valid ? int'(ret_count) : 0);
    end
  end

  // Free receiver slots, counting returns landing this cycle
  assign free_now = int'(init_credit) - in_flight + (ret_valid ? int'(ret_count) : 0);

  no_overflow: assert property (@(posedge clk) disable iff (!arst_n) !overflow)
    else begin fail_count++; $error("Receiver FIFO overflowed and lost a flit"); end

  ready_has_credit: assert property (@(posedge clk) disable iff (!arst_n)
    src_ready |-> free_now > int'(withhold))
    else begin fail_count++; $error("src_ready high without a free credit"); end

  batch_in_range: assert property (@(posedge clk) disable iff (!arst_n)
    crd_valid |-> (crd_count != '0) && (int'(crd_count) <= `CL_MAX_RET))
    else begin fail_count++; $error("Credit return batch out of range"); end

  // First cycle out of reset
  reset_state: assert property (@(posedge clk)
    $rose(arst_n) |-> !snk_valid && !crd_valid && (credits == init_credit))
    else begin fail_count++; $error("Outputs not in reset state after reset"); end

endmodule

// ==== sim/credit_link_tb.sv ====
// Credit link testbench
// Random, stalled and withheld traffic through the link. A queue
// scoreboard predicts the sink order, and every drain checks that all
// credits come back to the sender

`timescale 1ns/1ps

`include "credit_link_params.svh"

module credit_link_tb;
  import credit_link_pkg::*;

  localparam int DEPTH     = `CL_FIFO_DEPTH;
  localparam int LAT       = `CL_LINK_LAT;
  localparam int N_RAND    = 60;
  localparam int N_FINAL   = 30;
  localparam int STALL_CYC = DEPTH + 4 * LAT + 12;
  localparam int TEST_LEN  = N_RAND + 2 * STALL_CYC + N_FINAL;
  // Each test cycle may stretch by a round trip on the link
  localparam int LIMIT     = TEST_LEN * (LAT * 2 + 4) + 200;

  logic    clk;
  logic    arst_n;
  logic    src_valid;
  flit_t   src_flit;
  logic    src_ready;
  logic    snk_valid;
  flit_t   snk_flit;
  logic    snk_ready;
  credit_t init_credit;
  credit_t withhold;
  credit_t credits;

  // Scoreboard and bookkeeping
  flit_t       exp_q [$];
  int          errors    = 0;
  int          accepted  = 0;
  int          cycles    = 0;
  int          tests     = 0;
  int          test_base = 0;
  int          target;

  credit_link_top u_credit_link_top (
    .clk         (clk),
    .arst_n      (arst_n),
    .src_valid   (src_valid),
    .src_flit    (src_flit),
    .src_ready   (src_ready),
    .snk_valid   (snk_valid),
    .snk_flit    (snk_flit),
    .snk_ready   (snk_ready),
    .init_credit (init_credit),
    .withhold    (withhold),
    .credits     (credits)
  );

  // Checker sees the sender's incoming returns and the FIFO overflow flag
  bind credit_link_top credit_link_chk u_chk (
    .clk         (clk),
    .arst_n      (arst_n),
    .src_valid   (src_valid),
    .src_ready   (src_ready),
    .snk_valid   (snk_valid),
    .credits     (credits),
    .withhold    (withhold),
    .init_credit (init_credit),
    .ret_valid   (u_sender.u_credits.incr_valid),
    .ret_count   (u_sender.u_credits.incr),
    .crd_valid   (u_link.crd_valid),
    .crd_count   (u_link.crd_count),
    .overflow    (u_receiver.u_fifo.overflow)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Run limit
  always @(posedge clk) begin
    cycles++;
    if (cycles >= LIMIT) begin
      $display("Timeout: run stopped after %0d cycles with traffic pending", cycles);
      $display("Test failed");
      $finish;
    end
  end

  function automatic int total_errors();
    return errors + u_credit_link_top.u_chk.fail_count;
  endfunction

  function automatic flit_t random_flit();
    flit_t f;
    f.data = `CL_DATA_W'($urandom);
    f.last = 1'($urandom_range(1));
    return f;
  endfunction

  // ----------------------------
  // Scoreboard
  // ----------------------------

  // Handshakes sampled mid-cycle, away from the driving edge
  always @(negedge clk) begin
    if (arst_n && src_valid && src_ready) begin
      exp_q.push_back(src_flit);
      accepted++;
    end
    if (arst_n && snk_valid && snk_ready) begin
      assert (exp_q.size() > 0) else begin
        errors++;
        $error("Sink produced a flit while none was expected");
      end
      if (exp_q.size() > 0) begin
        assert (snk_flit == exp_q[0]) else begin
          errors++;
          $error("Mismatch snk_flit: got %h expected %h", snk_flit, exp_q[0]);
        end
        void'(exp_q.pop_front());
      end
    end
  end

  // ----------------------------
  // Stimulus tasks
  // ----------------------------

  // One cycle of traffic, an offered flit holds until it is taken
  task automatic traffic_cycle(input int valid_pct, input int ready_pct);
    logic taken;
    @(negedge clk);
    taken = src_valid && src_ready;
    @(posedge clk);
    #1;
    if (!src_valid || taken) begin
      src_valid = ($urandom_range(99) < valid_pct);
      src_flit  = random_flit();
    end
    snk_ready = ($urandom_range(99) < ready_pct);
  endtask

  task automatic check_credits(input credit_t exp);
    assert (credits == exp) else begin
      errors++;
      $error("Mismatch credits: got %h expected %h", credits, exp);
    end
  endtask

  // Empty the receiver, then give the returns time to cross the link
  task automatic drain();
    @(posedge clk);
    #1;
    src_valid = 1'b0;
    snk_ready = 1'b1;
    while (exp_q.size() != 0) @(negedge clk);
    for (int i = 0; i < 4 * LAT + 8 && credits != init_credit; i++) @(negedge clk);
    check_credits(init_credit);
  endtask

  // Source pushes every cycle into a stalled sink
  task automatic stall_fill(input int hold);
    int start;
    @(posedge clk);
    #1;
    withhold = credit_t'(hold);
    start    = accepted;
    repeat (STALL_CYC) traffic_cycle(100, 0);
    assert (accepted - start == DEPTH - hold) else begin
      errors++;
      $error("Mismatch accepted: got %h expected %h", accepted - start, DEPTH - hold);
    end
    assert (!src_ready) else begin
      errors++;
      $error("Mismatch src_ready: got %h expected %h", src_ready, 1'b0);
    end
    src_valid = 1'b0;
    withhold  = '0;
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("Test %0d %s finished with %0d errors", tests, name, total_errors() - test_base);
    test_base = total_errors();
  endtask

  // ----------------------------
  // Test sequence
  // ----------------------------

  initial begin
    void'($urandom(32'h98ab_2736));
    arst_n      = 1'b0;
    src_valid   = 1'b0;
    src_flit    = '0;
    snk_ready   = 1'b0;
    init_credit = credit_t'(DEPTH);
    withhold    = '0;
    repeat (8) @(posedge clk);
    #1;
    arst_n = 1'b1;

    @(negedge clk);
    assert (!snk_valid) else begin
      errors++;
      $error("Mismatch snk_valid: got %h expected %h", snk_valid, 1'b0);
    end
    check_credits(init_credit);
    end_test("reset state");

    target = accepted + N_RAND;
    while (accepted < target) traffic_cycle(50, 50);
    drain();
    end_test("random traffic");

    stall_fill(0);
    drain();
    end_test("sink stall");

    stall_fill(3);
    drain();
    end_test("withheld credits");

    target = accepted + N_FINAL;
    while (accepted < target) traffic_cycle(70, 100);
    drain();
    end_test("credit return");

    $display("Tests run: %0d, errors: %0d", tests, total_errors());
    if (total_errors() == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+hdl
hdl/credit_link_pkg.sv
hdl/credit_link_if.sv
hdl/credit_counter.sv
hdl/credit_sender.sv
hdl/credit_fifo.sv
hdl/credit_receiver.sv
hdl/credit_link_top.sv
sim/credit_link_chk.sv
sim/credit_link_tb.sv
